// File: common/ext_reg_pkg.sv
`default_nettype none

package ext_reg_pkg;

  // Request kind driven by the CPU memory stage
  typedef enum logic [1:0] {
    RWI_IDLE  = 2'b00,
    RWI_READ  = 2'b01,
    RWI_WRITE = 2'b10
  } rwi_t;

  typedef struct packed {
    rwi_t        rwi;   // Held until cpu_ack
    logic [31:0] addr;
    logic [31:0] wdata;
  } cpu_req_t;

  // One address word seen either as a register slot or as a memory address
  typedef union packed {
    struct packed {
      logic [26:0] window; // Compared against EXT_WINDOW
      logic [4:0]  idx;    // Register file slot
    } ext;
    logic [31:0] mem;
  } cpu_addr_u;

  // Window 0x20 puts the registers at byte addresses 0x400 to 0x41f
  localparam logic [26:0] EXT_WINDOW = 27'h000_0020;

  typedef struct packed {
    logic        rd;    // Read strobe, held until mem_ack
    logic        wr;    // Write strobe, held until mem_ack
    logic [31:0] addr;
    logic [31:0] wdata;
  } mem_req_t;

  typedef struct packed {
    logic        en;    // One-cycle write pulse
    logic [4:0]  idx;
    logic [31:0] data;
  } reg_wr_t;

  // Target codes where bit 1 selects memory and bit 0 marks a write
  localparam logic [1:0] TGT_EXT_RD = 2'd0;
  localparam logic [1:0] TGT_EXT_WR = 2'd1;
  localparam logic [1:0] TGT_MEM_RD = 2'd2;
  localparam logic [1:0] TGT_MEM_WR = 2'd3;

  typedef struct packed {
    logic [1:0]  target;
    cpu_addr_u   addr;
    logic [31:0] wdata;
  } op_t;

  localparam int unsigned FRAME_START_BIT = 7; // Marks the first byte of a frame

endpackage

`default_nettype wire

// File: esp_spi/esp_spi_rx.sv
`timescale 1ns/100ps
`default_nettype none

module esp_spi_rx #(
  parameter int unsigned SCLK_DIV = 4 // Clocks per strobe half-period
) (
  input  wire logic            clk,
  input  wire logic            arst_n,
  input  wire logic [7:0]      esp_in,   // Byte bus from the ESP32
  output logic                 sclk_out, // Strobe back to the ESP32
  output ext_reg_pkg::reg_wr_t reg_wr    // Write port of the register file
);
  import ext_reg_pkg::*;

  localparam int unsigned DIV_W = $clog2(SCLK_DIV);

  logic [DIV_W-1:0] div_cnt;
  logic             half_tick;  // Last clock of a half-period
  logic             sample;     // Strobe rises on this edge
  logic             start_byte;
  logic [2:0]       byte_cnt;   // Zero while no frame is open
  logic [4:0]       frame_idx;  // Index from the start byte
  logic [31:0]      shift_q;    // Data bytes, MSB first
  logic             wr_en_q;

  assign half_tick  = div_cnt == DIV_W'(SCLK_DIV - 1);
  assign sample     = half_tick && !sclk_out; // Rising edge of the strobe
  assign start_byte = esp_in[FRAME_START_BIT];

  // Strobe divider
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      div_cnt  <= '0;
      sclk_out <= 1'b0;
    end else if (half_tick) begin
      div_cnt  <= '0;
      sclk_out <= !sclk_out;
    end else begin
      div_cnt <= div_cnt + 1'b1;
    end
  end

  // Frame position where a start byte always reopens the frame
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      byte_cnt <= '0;
      wr_en_q  <= 1'b0;
    end else begin
      wr_en_q <= 1'b0;
      if (sample) begin
        if (start_byte) begin
          byte_cnt <= 3'd1;
        end else if (byte_cnt == 3'd4) begin
          byte_cnt <= '0; // Fourth data byte closes the frame
          wr_en_q  <= 1'b1;
        end else if (byte_cnt != '0) begin
          byte_cnt <= byte_cnt + 3'd1;
        end
        // Stray data bytes between frames fall through here
      end
    end
  end

  always_ff @(posedge clk) begin
    if (sample) begin
      if (start_byte) begin
        frame_idx <= esp_in[4:0];
      end else if (byte_cnt != '0) begin
        shift_q <= {shift_q[23:0], esp_in};
      end
    end
  end

  assign reg_wr = '{en: wr_en_q, idx: frame_idx, data: shift_q};

endmodule

`default_nettype wire

// File: ext_reg/ext_reg_file.sv
`timescale 1ns/100ps
`default_nettype none

module ext_reg_file (
  input  wire logic                 clk,
  input  wire logic                 arst_n,
  input  wire ext_reg_pkg::reg_wr_t reg_wr,  // From the ESP32 receiver
  input  wire logic                 rd_en,   // One-cycle read strobe
  input  wire logic [4:0]           rd_idx,
  output logic [31:0]               rd_data, // Valid with rd_ack
  output logic                      rd_ack
);

  localparam int unsigned NUM_REGS = 32;

  logic [31:0] regs [NUM_REGS];

  // Receiver is the only writer
  // CPU side never writes here
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      for (int i = 0; i < NUM_REGS; i++) begin
        regs[i] <= '0;
      end
    end else if (reg_wr.en) begin
      regs[reg_wr.idx] <= reg_wr.data;
    end
  end

  // Ack follows the strobe by one clock
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      rd_ack <= 1'b0;
    end else begin
      rd_ack <= rd_en;
    end
  end

  // Same-edge write is not forwarded so the new value shows on the next read
  always_ff @(posedge clk) begin
    if (rd_en) begin
      rd_data <= regs[rd_idx];
    end
  end

endmodule

`default_nettype wire

// File: mmio/mmio_decode.sv
`timescale 1ns/100ps
`default_nettype none

module mmio_decode (
  input  wire logic                  clk,
  input  wire logic                  arst_n,
  input  wire ext_reg_pkg::cpu_req_t cpu_req,  // Level from the CPU
  input  wire logic                  busy,     // Previous request still open
  output logic                       op_valid, // One cycle per taken request
  output ext_reg_pkg::op_t           op
);
  import ext_reg_pkg::*;

  cpu_addr_u  req_addr;
  logic       in_window;
  logic       is_write;
  logic       take;
  logic [1:0] target;

  assign req_addr  = cpu_req.addr;
  assign in_window = req_addr.ext.window == EXT_WINDOW;
  assign is_write  = cpu_req.rwi == RWI_WRITE;

  // Idle and the unused code are both ignored
  assign take = ((cpu_req.rwi == RWI_READ) || is_write) && !busy;

  always_comb begin
    if (in_window) begin
      target = is_write ? TGT_EXT_WR : TGT_EXT_RD;
    end else begin
      target = is_write ? TGT_MEM_WR : TGT_MEM_RD;
    end
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      op_valid <= 1'b0;
    end else begin
      op_valid <= take;
    end
  end

  // Op stays put until the next take as execute reads it throughout
  always_ff @(posedge clk) begin
    if (take) begin
      op <= '{target: target, addr: req_addr, wdata: cpu_req.wdata};
    end
  end

endmodule

`default_nettype wire

// File: mmio/mmio_execute.sv
`timescale 1ns/100ps
`default_nettype none

module mmio_execute (
  input  wire logic             clk,
  input  wire logic             arst_n,
  input  wire logic             op_valid,
  input  wire ext_reg_pkg::op_t op,
  output logic                  busy,
  output logic                  rd_en,    // Register file read strobe
  output logic [4:0]            rd_idx,
  output ext_reg_pkg::mem_req_t mem_req,  // Outside memory port
  input  wire logic             mem_ack,
  output logic                  done,     // Access finished, ack next clock
  output logic [1:0]            done_src  // Target of the finished op
);
  import ext_reg_pkg::*;

  localparam logic [2:0] ST_IDLE     = 3'd0;
  localparam logic [2:0] ST_RD_ISSUE = 3'd1; // rd_en out
  localparam logic [2:0] ST_RD_WAIT  = 3'd2; // Data comes back with rd_ack
  localparam logic [2:0] ST_WR       = 3'd3; // Window write, dropped
  localparam logic [2:0] ST_MEM      = 3'd4; // Strobes held
  localparam logic [2:0] ST_ACK      = 3'd5; // cpu_ack cycle

  logic [2:0] state, next_state;
  logic       mem_wait;

  assign mem_wait = state == ST_MEM;

  always_comb begin
    next_state = state;
    case (state)
      ST_IDLE: begin
        if (op_valid) begin
          case (op.target)
            TGT_EXT_RD: next_state = ST_RD_ISSUE;
            TGT_EXT_WR: next_state = ST_WR;
            default:    next_state = ST_MEM;
          endcase
        end
      end
      ST_RD_ISSUE:       next_state = ST_RD_WAIT;
      ST_RD_WAIT, ST_WR: next_state = ST_ACK;
      ST_MEM:            next_state = mem_ack ? ST_ACK : ST_MEM;
      default:           next_state = ST_IDLE;
    endcase
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      state <= ST_IDLE;
    end else begin
      state <= next_state;
    end
  end

  assign busy     = op_valid || (state != ST_IDLE); // Covers decode cycle too
  assign rd_en    = state == ST_RD_ISSUE;
  assign rd_idx   = op.addr.ext.idx;
  assign done     = (state == ST_RD_WAIT) || (state == ST_WR) || (mem_wait && mem_ack);
  assign done_src = op.target;

  assign mem_req = '{
    rd:    mem_wait && (op.target == TGT_MEM_RD),
    wr:    mem_wait && (op.target == TGT_MEM_WR),
    addr:  op.addr.mem,
    wdata: op.wdata
  };

endmodule

`default_nettype wire

// File: mmio/mmio_result.sv
`timescale 1ns/100ps
`default_nettype none

module mmio_result (
  input  wire logic        clk,
  input  wire logic        arst_n,
  input  wire logic        done,      // From execute
  input  wire logic [1:0]  done_src,  // Target code of that op
  input  wire logic        rd_ack,    // Register file answer
  input  wire logic [31:0] rd_data,
  input  wire logic [31:0] mem_rdata, // Valid with mem_ack
  output logic             cpu_ack,   // One pulse per request
  output logic [31:0]      cpu_rdata
);
  import ext_reg_pkg::*;

  logic [31:0] next_rdata;

  // Source that finished picks the data
  always_comb begin
    next_rdata = '0; // Writes return zero
    if (rd_ack) begin
      next_rdata = rd_data;
    end else if (done_src == TGT_MEM_RD) begin
      next_rdata = mem_rdata;
    end
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      cpu_ack <= 1'b0;
    end else begin
      cpu_ack <= done;
    end
  end

  // Only meaningful while cpu_ack is high
  always_ff @(posedge clk) begin
    if (done) begin
      cpu_rdata <= next_rdata;
    end
  end

endmodule

`default_nettype wire

// File: source/ext_reg_top.sv
`timescale 1ns/100ps
`default_nettype none

module ext_reg_top #(
  parameter int unsigned SCLK_DIV = 4 // Strobe half-period in clocks
) (
  input  wire logic                  hwclk,
  input  wire logic                  arst_n,
  input  wire logic [7:0]            esp_in,    // ESP32 byte bus
  output logic                       sclk_out,  // ESP32 strobe
  input  wire ext_reg_pkg::cpu_req_t cpu_req,
  output logic                       cpu_ack,
  output logic [31:0]                cpu_rdata,
  output logic                       busy,
  output ext_reg_pkg::mem_req_t      mem_req,   // Addresses outside the window
  input  wire logic                  mem_ack,
  input  wire logic [31:0]           mem_rdata
);
  import ext_reg_pkg::*;

  reg_wr_t     reg_wr;   // Receiver to register file
  logic        rd_en;
  logic [4:0]  rd_idx;
  logic [31:0] rd_data;
  logic        rd_ack;
  logic        op_valid; // Decode to execute
  op_t         op;
  logic        done;     // Execute to result
  logic [1:0]  done_src;

  esp_spi_rx #(
    .SCLK_DIV (SCLK_DIV)
  ) esp_spi_rx_i (
    .clk      (hwclk),
    .arst_n   (arst_n),
    .esp_in   (esp_in),
    .sclk_out (sclk_out),
    .reg_wr   (reg_wr)
  );

  ext_reg_file ext_reg_file_i (
    .clk     (hwclk),
    .arst_n  (arst_n),
    .reg_wr  (reg_wr),
    .rd_en   (rd_en),
    .rd_idx  (rd_idx),
    .rd_data (rd_data),
    .rd_ack  (rd_ack)
  );

  mmio_decode mmio_decode_i (
    .clk      (hwclk),
    .arst_n   (arst_n),
    .cpu_req  (cpu_req),
    .busy     (busy),
    .op_valid (op_valid),
    .op       (op)
  );

  mmio_execute mmio_execute_i (
    .clk      (hwclk),
    .arst_n   (arst_n),
    .op_valid (op_valid),
    .op       (op),
    .busy     (busy),
    .rd_en    (rd_en),
    .rd_idx   (rd_idx),
    .mem_req  (mem_req),
    .mem_ack  (mem_ack),
    .done     (done),
    .done_src (done_src)
  );

  mmio_result mmio_result_i (
    .clk       (hwclk),
    .arst_n    (arst_n),
    .done      (done),
    .done_src  (done_src),
    .rd_ack    (rd_ack),
    .rd_data   (rd_data),
    .mem_rdata (mem_rdata),
    .cpu_ack   (cpu_ack),
    .cpu_rdata (cpu_rdata)
  );

endmodule

`default_nettype wire

// File: verif/tb_ext_reg_top.sv
`timescale 1ns/100ps
`default_nettype none

module tb_ext_reg_top;
  import ext_reg_pkg::*;

  localparam int unsigned SCLK_DIV    = 2;
  localparam int unsigned CLK_PERIOD  = 4;
  localparam int unsigned NUM_FRAMES  = 12;            // Random frames in the readback test
  localparam int unsigned MAX_FRAMES  = 24;            // Frames plus stray and partial bytes
  localparam int unsigned MAX_REQS    = 72;
  localparam int unsigned WATCHDOG_NS = CLK_PERIOD * (MAX_FRAMES * 5 * 2 * SCLK_DIV
                                        + MAX_REQS * 8) + 2000;
  localparam logic [31:0] DATA_MASK   = 32'h7f7f_7f7f; // Data bytes keep bit 7 clear

  logic        clk = 1'b0;
  logic        arst_n;
  logic [7:0]  esp_in;
  logic        sclk_out;
  cpu_req_t    cpu_req;
  logic        cpu_ack;
  logic [31:0] cpu_rdata;
  logic        busy;
  mem_req_t    mem_req;
  logic        mem_ack;
  logic [31:0] mem_rdata;

  logic [15:0] lfsr_q;
  logic [31:0] shadow_regs [32]; // Expected register file
  logic [31:0] shadow_mem  [16]; // Expected memory words
  logic [31:0] mem_array   [16]; // Memory model storage
  logic [4:0]  frame_idx   [NUM_FRAMES];
  string       test_name, exp_name;
  rwi_t        exp_kind;
  logic [31:0] exp_addr, exp_wdata, exp_rdata, seen_addr, seen_wdata;
  logic        exp_ext, seen_wr, seen_rd, in_flight;
  int          cyc, take_cyc, mem_ack_cyc, err_cnt, check_cnt;
  int          req_cnt, ack_cnt, take_cnt, exp_mem_cnt, mem_strobe_cnt;

  ext_reg_top #(.SCLK_DIV(SCLK_DIV)) dut_i (
    .hwclk(clk), .arst_n(arst_n), .esp_in(esp_in), .sclk_out(sclk_out),
    .cpu_req(cpu_req), .cpu_ack(cpu_ack), .cpu_rdata(cpu_rdata), .busy(busy),
    .mem_req(mem_req), .mem_ack(mem_ack), .mem_rdata(mem_rdata)
  );

  always #(CLK_PERIOD / 2) clk = ~clk;
  always @(posedge clk) cyc <= cyc + 1; // Edge counter for latency checks

  // Fibonacci LFSR with taps 16 14 13 11
  function automatic logic [15:0] lfsr_step(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
  endfunction

  function automatic logic [31:0] rand_bits(input int unsigned n);
    logic [31:0] r;
    r = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_q = lfsr_step(lfsr_q); // One step per bit
      r = {r[30:0], lfsr_q[0]};
    end
    return r;
  endfunction

  function automatic logic [31:0] mem_fill(input int unsigned i);
    return 32'hc3a5_0000 + i * 32'h0011_0203;
  endfunction

  function automatic logic [31:0] ext_addr(input logic [4:0] idx);
    return {EXT_WINDOW, idx};
  endfunction

  function automatic logic [31:0] mem_addr(input logic [3:0] idx);
    return 32'h8000_0000 | {26'd0, idx, 2'b00}; // Well outside the window
  endfunction

  // Expected cpu_rdata from the shadow copies
  // Writes return zero and the window is read-only
  function automatic logic [31:0] ref_rdata(input rwi_t kind, input logic [31:0] addr);
    if (kind == RWI_WRITE) return '0;
    if (addr[31:5] == EXT_WINDOW) return shadow_regs[addr[4:0]];
    return shadow_mem[addr[5:2]];
  endfunction

  task automatic compare_word(input string tname, input string what,
                              input logic [31:0] exp, input logic [31:0] act);
    check_cnt++;
    if (exp !== act) begin
      err_cnt++;
      $display("Mismatch %s: %s expected %h actual %h", tname, what, exp, act);
    end
  endtask

  task automatic wait_sclk_fall();
    logic was_high;
    @(negedge clk);
    was_high = sclk_out;
    @(negedge clk);
    while (!(was_high && !sclk_out)) begin
      was_high = sclk_out;
      @(negedge clk);
    end
  endtask

  task automatic send_byte(input logic [7:0] b);
    wait_sclk_fall();
    @(posedge clk);
    esp_in <= b; // Sampled on the next strobe rise
  endtask

  task automatic send_frame(input logic [4:0] idx, input logic [31:0] data);
    send_byte({3'b100, idx});
    for (int i = 3; i >= 0; i--) send_byte(data[i*8 +: 8]); // MSB first
    wait_sclk_fall(); // Last byte sampled and written by now
    shadow_regs[idx] = data;
  endtask

  // Drive a request and hold it until cpu_ack
  task automatic cpu_issue(input rwi_t kind, input logic [31:0] addr, input logic [31:0] wdata);
    @(posedge clk);
    exp_name  = test_name;
    exp_kind  = kind;
    exp_addr  = addr;
    exp_wdata = wdata;
    exp_ext   = addr[31:5] == EXT_WINDOW;
    exp_rdata = ref_rdata(kind, addr);
    if (!exp_ext) exp_mem_cnt++;
    if (!exp_ext && kind == RWI_WRITE) shadow_mem[addr[5:2]] = wdata;
    req_cnt++;
    cpu_req.rwi   <= kind;
    cpu_req.addr  <= addr;
    cpu_req.wdata <= wdata;
    @(negedge clk);
    while (!cpu_ack) @(negedge clk);
  endtask

  task automatic cpu_drop();
    @(posedge clk);
    cpu_req.rwi <= RWI_IDLE;
  endtask

  task automatic cpu_access(input rwi_t kind, input logic [31:0] addr, input logic [31:0] wdata);
    cpu_issue(kind, addr, wdata);
    cpu_drop();
  endtask

  // Memory model that acks after 0 to 3 cycles
  always begin
    @(posedge clk);
    if (mem_req.rd || mem_req.wr) begin
      mem_strobe_cnt++;
      seen_addr  = mem_req.addr;
      seen_wdata = mem_req.wdata;
      seen_wr    = mem_req.wr;
      seen_rd    = mem_req.rd;
      repeat (rand_bits(2)) @(posedge clk);
      if (mem_req.wr) mem_array[mem_req.addr[5:2]] = mem_req.wdata;
      mem_rdata <= mem_array[mem_req.addr[5:2]];
      mem_ack   <= 1'b1;
      @(posedge clk);
      mem_ack <= 1'b0;
    end
  end

  // Checker samples at the falling edge where outputs are settled
  always @(negedge clk) begin
    if (!arst_n) begin
      check_cnt++;
      if (busy || cpu_ack || sclk_out || mem_req.rd || mem_req.wr) begin
        err_cnt++;
        $display("Outputs are not all low while reset is held");
      end
    end else begin
      if (in_flight && !busy) begin
        err_cnt++;
        $display("busy went low before cpu_ack in %s", exp_name);
      end
      if (mem_ack) mem_ack_cyc = cyc;
      if (cpu_ack) begin
        ack_cnt++;
        if (!in_flight) begin
          err_cnt++;
          $display("cpu_ack came with no request in flight in %s", exp_name);
        end
        compare_word(exp_name, "cpu_rdata", exp_rdata, cpu_rdata);
        compare_word(exp_name, "mem strobe count", exp_mem_cnt, mem_strobe_cnt);
        if (exp_ext) begin
          compare_word(exp_name, "ack latency", (exp_kind == RWI_WRITE) ? 2 : 3, cyc - take_cyc);
        end else begin
          compare_word(exp_name, "ack after mem_ack", mem_ack_cyc + 1, cyc);
          compare_word(exp_name, "mem addr", exp_addr, seen_addr);
          compare_word(exp_name, "mem write strobe", exp_kind == RWI_WRITE, seen_wr);
          compare_word(exp_name, "mem read strobe", exp_kind == RWI_READ, seen_rd);
          if (exp_kind == RWI_WRITE) compare_word(exp_name, "mem wdata", exp_wdata, seen_wdata);
        end
        in_flight = 1'b0;
      end
      if (cpu_req.rwi != RWI_IDLE && !busy) begin
        take_cyc  = cyc + 1; // Taken on the coming edge
        take_cnt++;
        in_flight = 1'b1;
      end
    end
  end

  initial begin
    logic [4:0]  idx_a, ridx;
    logic [1:0]  sel;
    logic [31:0] rdata;
    lfsr_q = 16'd98;
    cyc = 0; err_cnt = 0; check_cnt = 0; req_cnt = 0; ack_cnt = 0; take_cnt = 0;
    exp_mem_cnt = 0; mem_strobe_cnt = 0; in_flight = 1'b0; mem_ack_cyc = 0;
    for (int i = 0; i < 32; i++) shadow_regs[i] = '0;
    for (int i = 0; i < 16; i++) begin
      shadow_mem[i] = mem_fill(i);
      mem_array[i]  = mem_fill(i);
    end
    arst_n = 1'b0;
    esp_in = '0;
    cpu_req.rwi = RWI_IDLE;
    cpu_req.addr = '0;
    cpu_req.wdata = '0;
    mem_ack = 1'b0;
    mem_rdata = '0;
    test_name = "reset_state";
    repeat (8) @(posedge clk);
    arst_n <= 1'b1;
    for (int i = 0; i < 4; i++) cpu_access(RWI_READ, ext_addr(5'(i * 9)), '0);

    test_name = "frame_readback";
    for (int i = 0; i < NUM_FRAMES; i++) begin
      frame_idx[i] = 5'(rand_bits(5));
      send_frame(frame_idx[i], rand_bits(32) & DATA_MASK);
    end
    for (int i = 0; i < NUM_FRAMES; i++) cpu_access(RWI_READ, ext_addr(frame_idx[i]), '0);

    test_name = "framing";
    idx_a = 5'(rand_bits(5));
    send_byte(8'h15); // Strays between frames
    send_byte(8'h2a);
    send_byte({3'b100, idx_a}); // Cut short by the next start byte
    send_byte(8'h11);
    send_byte(8'h22);
    send_frame(idx_a + 5'd7, rand_bits(32) & DATA_MASK);
    send_byte(8'h33);
    cpu_access(RWI_READ, ext_addr(idx_a), '0);
    cpu_access(RWI_READ, ext_addr(idx_a + 5'd7), '0);

    test_name = "read_only_window";
    for (int i = 0; i < 3; i++) begin
      cpu_access(RWI_WRITE, ext_addr(frame_idx[i]), rand_bits(32));
      cpu_access(RWI_READ, ext_addr(frame_idx[i]), '0);
    end

    test_name = "mem_passthrough";
    for (int i = 0; i < 12; i++) begin
      sel   = 2'(rand_bits(1));
      ridx  = 5'(rand_bits(4));
      rdata = rand_bits(32);
      cpu_access(sel[0] ? RWI_WRITE : RWI_READ, mem_addr(ridx[3:0]), rdata);
    end

    test_name = "back_pressure";
    for (int i = 0; i < 16; i++) begin
      sel   = 2'(rand_bits(2)); // Bit 1 picks memory and bit 0 a write
      ridx  = 5'(rand_bits(5));
      rdata = rand_bits(32);
      cpu_issue(sel[0] ? RWI_WRITE : RWI_READ,
                sel[1] ? mem_addr(ridx[3:0]) : ext_addr(ridx), rdata);
    end
    cpu_drop();
    repeat (6) @(posedge clk);
    compare_word("back_pressure", "ack count", req_cnt, ack_cnt);
    compare_word("back_pressure", "take count", req_cnt, take_cnt);

    $display("Checks %0d, errors %0d, requests %0d, acks %0d", check_cnt, err_cnt,
             req_cnt, ack_cnt);
    if (err_cnt == 0) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

  initial begin
    #(WATCHDOG_NS);
    $display("Timeout after %0d ns, the run did not complete", WATCHDOG_NS);
    $display("Test FAILED");
    $finish;
  end

endmodule

`default_nettype wire

// File: flist.f
common/ext_reg_pkg.sv
esp_spi/esp_spi_rx.sv
ext_reg/ext_reg_file.sv
mmio/mmio_decode.sv
mmio/mmio_execute.sv
mmio/mmio_result.sv
source/ext_reg_top.sv
verif/tb_ext_reg_top.sv
